//--- cmdq_pkg.sv
package cmdq_pkg;

    // Word address into the on-chip SRAM, 256 words
    localparam int ADDR_W = 8;

    // Data word carried on the internal bus and the host ports
    localparam int DATA_W = 32;

    // Command entry layout from the top bit down is opcode, address, data
    localparam int CMD_W = 1 + ADDR_W + DATA_W;

    typedef enum logic {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } cmd_op_e;

    // Bus master sequencing
    typedef enum logic [1:0] {
        WBM_IDLE = 2'd0,
        WBM_BUS  = 2'd1,
        WBM_DONE = 2'd2
    } wbm_state_e;

endpackage

//--- pending_size.sv
module pending_size #(
    parameter int SIZE      = 8,
    parameter int ALM_FULL  = SIZE - 1,
    parameter int ALM_EMPTY = 1
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      incr,
    input  logic                      decr,
    output logic                      empty,
    output logic                      alm_empty,
    output logic                      full,
    output logic                      alm_full,
    output logic [$clog2(SIZE+1)-1:0] size
);
    localparam int SIZEW = $clog2(SIZE + 1);
    localparam int ADDRW = (SIZE > 1) ? $clog2(SIZE) : 1;

    // A push and a pop on the same edge leave the count unchanged
    logic grow;
    logic shrink;

    assign grow   = incr & ~decr;
    assign shrink = decr & ~incr;

    if (SIZE == 1) begin : g_size_eq1

        logic busy_r;

        always_ff @(posedge clk) begin
            if (reset) begin
                busy_r <= 1'b0;
            end else if (grow) begin
                busy_r <= 1'b1;
            end else if (shrink) begin
                busy_r <= 1'b0;
            end
        end

        // With a single slot the almost flags carry no information
        assign empty     = ~busy_r;
        assign full      = busy_r;
        assign alm_empty = 1'b1;
        assign alm_full  = 1'b1;
        assign size      = busy_r;

    end else begin : g_size_gt1

        logic             empty_r;
        logic             full_r;
        logic             alm_empty_r;
        logic             alm_full_r;
        logic [ADDRW-1:0] used_r;

        // Threshold crossings are detected one step ahead with equality only
        logic at_alm_empty;
        logic above_alm_empty;
        logic at_alm_full;
        logic below_alm_full;

        assign at_alm_empty    = (used_r == ADDRW'(ALM_EMPTY));
        assign above_alm_empty = (used_r == ADDRW'(ALM_EMPTY + 1));
        assign at_alm_full     = (used_r == ADDRW'(ALM_FULL));
        assign below_alm_full  = (used_r == ADDRW'(ALM_FULL - 1));

        always_ff @(posedge clk) begin
            if (reset) begin
                alm_empty_r <= 1'b1;
                alm_full_r  <= 1'b0;
            end else if (grow) begin
                if (at_alm_empty) begin
                    alm_empty_r <= 1'b0;
                end
                if (below_alm_full) begin
                    alm_full_r <= 1'b1;
                end
            end else if (shrink) begin
                if (at_alm_full) begin
                    alm_full_r <= 1'b0;
                end
                if (above_alm_empty) begin
                    alm_empty_r <= 1'b1;
                end
            end
        end

        if (SIZE > 2) begin : g_size_gt2

            logic at_one;
            logic at_last;

            assign at_one  = (used_r == ADDRW'(1));
            assign at_last = (used_r == ADDRW'(SIZE - 1));

            always_ff @(posedge clk) begin
                if (reset) begin
                    empty_r <= 1'b1;
                    full_r  <= 1'b0;
                    used_r  <= '0;
                end else if (grow) begin
                    empty_r <= 1'b0;
                    full_r  <= at_last;
                    used_r  <= used_r + ADDRW'(1);
                end else if (shrink) begin
                    full_r  <= 1'b0;
                    empty_r <= at_one;
                    used_r  <= used_r - ADDRW'(1);
                end
            end

        end else begin : g_size_eq2

            // Two slots, so the flags follow from each other without compares
            always_ff @(posedge clk) begin
                if (reset) begin
                    empty_r <= 1'b1;
                    full_r  <= 1'b0;
                    used_r  <= '0;
                end else begin
                    if (grow) begin
                        empty_r <= 1'b0;
                        full_r  <= ~empty_r;
                    end else if (shrink) begin
                        full_r  <= 1'b0;
                        empty_r <= ~full_r;
                    end
                    used_r <= used_r ^ (incr ^ decr);
                end
            end

        end

        // A power of two wraps the counter to zero when full, so full is the top bit
        if (SIZEW > ADDRW) begin : g_pow2
            assign size = {full_r, used_r};
        end else begin : g_not_pow2
            assign size = used_r;
        end

        assign empty     = empty_r;
        assign full      = full_r;
        assign alm_empty = alm_empty_r;
        assign alm_full  = alm_full_r;

    end

endmodule

//--- cmd_fifo.sv
module cmd_fifo #(
    parameter int DEPTH     = 8,
    parameter int WIDTH     = 32,
    parameter int ALM_FULL  = DEPTH - 1,
    parameter int ALM_EMPTY = 1
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push,
    input  logic [WIDTH-1:0]           push_data,
    input  logic                       pop,
    output logic [WIDTH-1:0]           head_data,
    output logic                       empty,
    output logic                       full,
    output logic                       alm_empty,
    output logic                       alm_full,
    output logic [$clog2(DEPTH+1)-1:0] count
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // Pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Show-ahead, the oldest entry is always on the output
    assign head_data = mem[rd_ptr];

    pending_size #(
        .SIZE      (DEPTH),
        .ALM_FULL  (ALM_FULL),
        .ALM_EMPTY (ALM_EMPTY)
    ) count_i (
        .clk       (clk),
        .reset     (reset),
        .incr      (push),
        .decr      (pop),
        .empty     (empty),
        .alm_empty (alm_empty),
        .full      (full),
        .alm_full  (alm_full),
        .size      (count)
    );

endmodule

//--- wb_cmd_master.sv
module wb_cmd_master import cmdq_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              cmd_empty,
    input  logic [CMD_W-1:0]  cmd_head,
    output logic              cmd_pop,
    input  logic              rsp_full,
    output logic              rsp_push,
    output logic [DATA_W-1:0] rsp_data,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output logic [ADDR_W-1:0] wb_adr,
    output logic [DATA_W-1:0] wb_dat_w,
    input  logic              wb_ack,
    input  logic [DATA_W-1:0] wb_dat_r
);
    wbm_state_e        state;
    cmd_op_e           head_op;
    logic [ADDR_W-1:0] head_adr;
    logic [DATA_W-1:0] head_dat;
    logic              can_start;
    logic              bus_done;

    // Split the head entry into its fields
    assign head_op  = cmd_op_e'(cmd_head[CMD_W-1]);
    assign head_adr = cmd_head[DATA_W +: ADDR_W];
    assign head_dat = cmd_head[DATA_W-1:0];

    // A read only starts when its response has somewhere to go
    assign can_start = ~cmd_empty & ((head_op == CMD_WRITE) | ~rsp_full);
    assign bus_done  = (state == WBM_BUS) & wb_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= WBM_IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
        end else begin
            case (state)
                WBM_IDLE: begin
                    if (can_start) begin
                        state  <= WBM_BUS;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                    end
                end
                WBM_BUS: begin
                    if (wb_ack) begin
                        state  <= WBM_DONE;
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                    end
                end
                default: begin
                    state <= WBM_IDLE;
                end
            endcase
        end
    end

    // Address, data and direction are captured when the cycle opens
    always_ff @(posedge clk) begin
        if (state == WBM_IDLE && can_start) begin
            wb_we    <= (head_op == CMD_WRITE);
            wb_adr   <= head_adr;
            wb_dat_w <= head_dat;
        end
    end

    // The command leaves the queue on the ack edge, and a read hands over its data
    assign cmd_pop  = bus_done;
    assign rsp_push = bus_done & ~wb_we;
    assign rsp_data = wb_dat_r;

endmodule

//--- wb_sram.sv
module wb_sram import cmdq_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [ADDR_W-1:0] wb_adr,
    input  logic [DATA_W-1:0] wb_dat_w,
    output logic              wb_ack,
    output logic [DATA_W-1:0] wb_dat_r
);
    logic [DATA_W-1:0] mem [2**ADDR_W];
    logic              req;

    assign req = wb_cyc & wb_stb;

    // Ack comes one clock after the strobe and lasts a single clock
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req & ~wb_ack;
        end
    end

    // Writes land in the acknowledging cycle
    always_ff @(posedge clk) begin
        if (req && wb_ack && wb_we) begin
            mem[wb_adr] <= wb_dat_w;
        end
    end

    // Read data is fetched during the wait state and is valid with ack
    always_ff @(posedge clk) begin
        if (req && !wb_ack) begin
            wb_dat_r <= mem[wb_adr];
        end
    end

endmodule

//--- cmdq_top.sv
module cmdq_top import cmdq_pkg::*; #(
    parameter int CMD_DEPTH     = 8,
    parameter int RSP_DEPTH     = 4,
    parameter int CMD_ALM_FULL  = 6,
    parameter int RSP_ALM_EMPTY = 1
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              cmd_valid,
    input  logic              cmd_write,
    input  logic [ADDR_W-1:0] cmd_addr,
    input  logic [DATA_W-1:0] cmd_wdata,
    output logic              cmd_ready,
    output logic              cmd_alm_full,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output logic [DATA_W-1:0] rsp_data
);
    logic [CMD_W-1:0]  cmd_word;
    logic              cmd_push;
    logic              cmd_pop;
    logic              cmd_empty;
    logic              cmd_full;
    logic [CMD_W-1:0]  cmd_head;

    logic              rsp_push;
    logic              rsp_pop;
    logic              rsp_empty;
    logic              rsp_full;
    logic [DATA_W-1:0] rsp_push_data;

    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    logic [DATA_W-1:0] wb_dat_w;
    logic              wb_ack;
    logic [DATA_W-1:0] wb_dat_r;

    assign cmd_word  = {(cmd_write ? CMD_WRITE : CMD_READ), cmd_addr, cmd_wdata};
    assign cmd_ready = ~cmd_full;
    assign cmd_push  = cmd_valid & cmd_ready;

    assign rsp_valid = ~rsp_empty;
    assign rsp_pop   = rsp_valid & rsp_ready;

    cmd_fifo #(
        .DEPTH     (CMD_DEPTH),
        .WIDTH     (CMD_W),
        .ALM_FULL  (CMD_ALM_FULL),
        .ALM_EMPTY (1)
    ) cmd_fifo_i (
        .clk       (clk),
        .reset     (reset),
        .push      (cmd_push),
        .push_data (cmd_word),
        .pop       (cmd_pop),
        .head_data (cmd_head),
        .empty     (cmd_empty),
        .full      (cmd_full),
        .alm_empty (),
        .alm_full  (cmd_alm_full),
        .count     ()
    );

    // Read data only, so the response entry is one data word wide
    cmd_fifo #(
        .DEPTH     (RSP_DEPTH),
        .WIDTH     (DATA_W),
        .ALM_FULL  (RSP_DEPTH - 1),
        .ALM_EMPTY (RSP_ALM_EMPTY)
    ) rsp_fifo_i (
        .clk       (clk),
        .reset     (reset),
        .push      (rsp_push),
        .push_data (rsp_push_data),
        .pop       (rsp_pop),
        .head_data (rsp_data),
        .empty     (rsp_empty),
        .full      (rsp_full),
        .alm_empty (),
        .alm_full  (),
        .count     ()
    );

    wb_cmd_master wb_cmd_master_i (
        .clk       (clk),
        .reset     (reset),
        .cmd_empty (cmd_empty),
        .cmd_head  (cmd_head),
        .cmd_pop   (cmd_pop),
        .rsp_full  (rsp_full),
        .rsp_push  (rsp_push),
        .rsp_data  (rsp_push_data),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r)
    );

    wb_sram wb_sram_i (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r)
    );

endmodule

//--- tb_clock.sv
module tb_clock #(
    parameter int HALF_PERIOD = 10
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // Free running clock with a 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

//--- tb_cmdq.sv
module tb_cmdq import cmdq_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int STIM_DEPTH = 64;
    localparam int RAND_COUNT = 12;

    // Default FIFO depths of the DUT
    localparam int CMD_DEPTH = 8;
    localparam int RSP_DEPTH = 4;

    // Test indices into the per-test error counts
    localparam int T_RESET = 0;
    localparam int T_RAW   = 1;
    localparam int T_BP    = 2;
    localparam int T_ALM   = 3;
    localparam int T_HELD  = 4;
    localparam int T_RAND  = 5;
    localparam int N_TESTS = 6;

    // Entry kinds in the stimulus file
    localparam logic [3:0] K_READ    = 4'h0;
    localparam logic [3:0] K_WRITE   = 4'h1;
    localparam logic [3:0] K_SECTION = 4'h2;
    localparam logic [3:0] K_END     = 4'hf;

    logic              clk;
    logic              reset;
    logic              cmd_valid;
    logic              cmd_write;
    logic [ADDR_W-1:0] cmd_addr;
    logic [DATA_W-1:0] cmd_wdata;
    logic              cmd_ready;
    logic              cmd_alm_full;
    logic              rsp_valid;
    logic              rsp_ready;
    logic [DATA_W-1:0] rsp_data;

    logic [51:0]       stim_mem [STIM_DEPTH];
    logic [DATA_W-1:0] exp_q [$];
    logic [DATA_W-1:0] model [2**ADDR_W];
    logic [ADDR_W-1:0] rand_addr [RAND_COUNT];
    string             test_name [N_TESTS];
    int                errs [N_TESTS];
    logic [7:0]        hold_cnt;
    logic              prev_valid;
    logic              prev_ready;
    logic [DATA_W-1:0] prev_data;
    logic              saw_stall;
    int                held_cycles;
    int                stall_checks;
    int                cur_test;
    int                cycles = 0;
    int                cycle_limit = 100000;
    integer            seed;

    tb_clock clock_i (
        .clk (clk)
    );

    cmdq_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid    (cmd_valid),
        .cmd_write    (cmd_write),
        .cmd_addr     (cmd_addr),
        .cmd_wdata    (cmd_wdata),
        .cmd_ready    (cmd_ready),
        .cmd_alm_full (cmd_alm_full),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_data     (rsp_data)
    );

    // Watchdog that ends a run which has stopped making progress
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Advance to the next falling edge, check outputs and drive rsp_ready
    task automatic next_cycle();
        logic [DATA_W-1:0] want;
        @(negedge clk);
        // The head of the response FIFO must not move without a pop
        if (prev_valid && !prev_ready) begin
            held_cycles++;
            assert (rsp_valid) else begin
                $display("held_rsp_data: response withdrawn while rsp_ready was low");
                errs[T_HELD]++;
            end
            assert (rsp_data == prev_data) else begin
                $display("FAILED held_rsp_data: expected %h, actual %h", prev_data, rsp_data);
                errs[T_HELD]++;
            end
        end
        if (!cmd_ready) begin
            stall_checks++;
            assert (cmd_alm_full) else begin
                $display("alm_full_flag: cmd_alm_full is low while cmd_ready is low");
                errs[T_ALM]++;
            end
        end
        // Once stalled under back-pressure the port stays stalled
        if (!rsp_ready && saw_stall) begin
            assert (!cmd_ready) else begin
                $display("back_pressure: cmd_ready rose while responses were held");
                errs[T_BP]++;
            end
        end
        // The master can only stop for good once both FIFOs are full of reads
        if (!rsp_ready && !cmd_ready && exp_q.size() > CMD_DEPTH + RSP_DEPTH) begin
            saw_stall = 1'b1;
        end
        rsp_ready = (hold_cnt == 8'd0);
        if (hold_cnt != 8'd0) begin
            hold_cnt = hold_cnt - 8'd1;
        end
        // A response seen here is popped on the next rising edge
        if (rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                $display("%s: response arrived with no read outstanding", test_name[cur_test]);
                errs[cur_test]++;
            end else begin
                want = exp_q.pop_front();
                assert (rsp_data == want) else begin
                    $display("FAILED %s: expected %h, actual %h",
                             test_name[cur_test], want, rsp_data);
                    errs[cur_test]++;
                end
            end
        end
        prev_valid = rsp_valid;
        prev_ready = rsp_ready;
        prev_data  = rsp_data;
    endtask

    task automatic send_command(input logic [3:0] kind, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] data, input logic [7:0] stall);
        next_cycle();
        cmd_valid = 1'b1;
        cmd_write = (kind == K_WRITE);
        cmd_addr  = addr;
        cmd_wdata = (kind == K_WRITE) ? data : '0;
        if (stall != 8'd0) begin
            hold_cnt = stall;
        end
        if (kind == K_WRITE) begin
            model[addr] = data;
        end else begin
            exp_q.push_back(data);
        end
        // Taken on the next rising edge once the port is ready
        while (!cmd_ready) begin
            next_cycle();
        end
    endtask

    task automatic drain_responses();
        next_cycle();
        cmd_valid = 1'b0;
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        // The last response leaves the FIFO on the following edge
        next_cycle();
        assert (!rsp_valid) else begin
            $display("%s: rsp_valid still high after all reads returned", test_name[cur_test]);
            errs[cur_test]++;
        end
        assert (!cmd_alm_full) else begin
            $display("alm_full_flag: cmd_alm_full still high after the queue drained");
            errs[T_ALM]++;
        end
    endtask

    task automatic report_test(input int idx);
        if (errs[idx] == 0) begin
            $display("test %s: ok", test_name[idx]);
        end else begin
            $display("test %s: %0d errors", test_name[idx], errs[idx]);
        end
    endtask

    initial begin
        logic [51:0] entry;
        int          n_entries;
        int          n_cmds;
        bit          found;
        int          passed;
        int          total;
        reset        = 1'b1;
        cmd_valid    = 1'b0;
        cmd_write    = 1'b0;
        cmd_addr     = '0;
        cmd_wdata    = '0;
        rsp_ready    = 1'b1;
        hold_cnt     = 8'd0;
        prev_valid   = 1'b0;
        prev_ready   = 1'b1;
        prev_data    = '0;
        saw_stall    = 1'b0;
        held_cycles  = 0;
        stall_checks = 0;
        cur_test     = T_RESET;
        seed         = 32'h3cbf_26d0;
        test_name    = '{"reset_state", "read_after_write", "back_pressure",
                         "alm_full_flag", "held_rsp_data", "random_rw"};
        foreach (errs[i]) begin
            errs[i] = 0;
        end

        $readmemh("cmdq_stim.txt", stim_mem);
        // Count the commands up to the end marker to size the timeout
        n_entries = 0;
        n_cmds    = 0;
        found     = 1'b0;
        while (!found && n_entries < STIM_DEPTH) begin
            if (stim_mem[n_entries][51:48] == K_END) begin
                found = 1'b1;
            end else begin
                if (stim_mem[n_entries][51:48] != K_SECTION) begin
                    n_cmds++;
                end
                n_entries++;
            end
        end
        cycle_limit = 4 * (n_cmds + 2 * RAND_COUNT) * 2 + 200;

        repeat (3) @(negedge clk);
        reset = 1'b0;
        assert (cmd_ready) else begin
            $display("reset_state: cmd_ready is low after reset");
            errs[T_RESET]++;
        end
        assert (!rsp_valid) else begin
            $display("reset_state: rsp_valid is high after reset");
            errs[T_RESET]++;
        end
        assert (!cmd_alm_full) else begin
            $display("reset_state: cmd_alm_full is high after reset");
            errs[T_RESET]++;
        end
        report_test(T_RESET);

        if (!found) begin
            $display("stimulus file cmdq_stim.txt has no end marker");
            errs[T_RAW]++;
            errs[T_BP]++;
            report_test(T_RAW);
            report_test(T_BP);
        end else begin
            cur_test = T_RAW;
            for (int i = 0; i < n_entries; i++) begin
                entry = stim_mem[i];
                if (entry[51:48] == K_SECTION) begin
                    drain_responses();
                    if (cur_test == T_BP) begin
                        assert (saw_stall) else begin
                            $display("back_pressure: cmd_ready never dropped under back-pressure");
                            errs[T_BP]++;
                        end
                    end
                    report_test(cur_test);
                    if (cur_test == T_RAW) begin
                        cur_test  = T_BP;
                        saw_stall = 1'b0;
                    end
                end else begin
                    send_command(entry[51:48], entry[47:40], entry[39:8], entry[7:0]);
                end
            end
        end

        // Random writes first, then reads of the same addresses
        cur_test = T_RAND;
        for (int i = 0; i < RAND_COUNT; i++) begin
            rand_addr[i] = ADDR_W'($random(seed));
            send_command(K_WRITE, rand_addr[i], DATA_W'($random(seed)), 8'd0);
        end
        for (int i = 0; i < RAND_COUNT; i++) begin
            send_command(K_READ, rand_addr[i], model[rand_addr[i]], 8'd0);
        end
        drain_responses();
        report_test(T_RAND);

        assert (stall_checks > 0) else begin
            $display("alm_full_flag: the command port never filled during the run");
            errs[T_ALM]++;
        end
        report_test(T_ALM);
        assert (held_cycles > 0) else begin
            $display("held_rsp_data: no response was ever held with rsp_ready low");
            errs[T_HELD]++;
        end
        report_test(T_HELD);

        total  = 0;
        passed = 0;
        foreach (errs[i]) begin
            total += errs[i];
            if (errs[i] == 0) begin
                passed++;
            end
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 N_TESTS, passed, N_TESTS - passed, total);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
cmdq_pkg.sv
pending_size.sv
cmd_fifo.sv
wb_cmd_master.sv
wb_sram.sv
cmdq_top.sv
tb_clock.sv
tb_cmdq.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module tb_cmdq || exit 1
sim_out=$(./obj_dir/Vtb_cmdq)
echo "$sim_out"
echo "$sim_out" | grep -qx "ALL CHECKS PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

//--- cmdq_stim.txt
// Columns: kind_addr_data_stall, kind 0 read (data is expected), 1 write, 2 end of section, f end
// Stall holds rsp_ready low for that many cycles once the command is issued
// Section 1, read after write including a rewritten address
1_00_a5a50001_00
1_01_5a5a0002_00
1_02_deadbeef_00
1_03_cafef00d_00
0_00_a5a50001_00
0_02_deadbeef_00
1_7f_12345678_00
0_01_5a5a0002_00
0_7f_12345678_00
1_02_0badc0de_00
0_02_0badc0de_00
0_03_cafef00d_00
1_ff_ffff0000_00
0_ff_ffff0000_00
1_00_00c0ffee_00
0_00_00c0ffee_00
2_00_00000000_00
// Section 2, sixteen reads with responses held back for 64 cycles
0_00_00c0ffee_40
0_01_5a5a0002_00
0_02_0badc0de_00
0_03_cafef00d_00
0_7f_12345678_00
0_ff_ffff0000_00
0_00_00c0ffee_00
0_01_5a5a0002_00
0_02_0badc0de_00
0_03_cafef00d_00
0_7f_12345678_00
0_ff_ffff0000_00
0_00_00c0ffee_00
0_01_5a5a0002_00
0_02_0badc0de_00
0_03_cafef00d_00
2_00_00000000_00
f_00_00000000_00
